//--- filelist.f
logic/mos_isa_pkg.sv
logic/exec_cfg_pkg.sv
logic/opcode_decode.sv
logic/mos_alu.sv
logic/exec_fsm.sv
logic/cycle_timer.sv
logic/zp_ram.sv
logic/acc_status_regs.sv
logic/mos_exec_top.sv
dv/mos_exec_assertions.sv
dv/mos_exec_checker.sv
dv/mos_exec_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f filelist.f --top-module mos_exec_tb
out=$(./obj_dir/Vmos_exec_tb) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'STATUS: PASS'

//--- dv/mos_exec_tb.sv
// ------------------------------
// Execute stage testbench
// Clock, reset, directed and
// random instructions with
// response back-pressure
// ------------------------------

module mos_exec_tb
  import mos_isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // Falling edges allowed per wait loop
  localparam int TIMEOUT     = 64;
  localparam int RANDOM_CMDS = 300;

  localparam logic [7:0] LEGAL_OPS [27] = '{
    OP_ADC_IMM, OP_ADC_ZP, OP_SBC_IMM, OP_SBC_ZP, OP_AND_IMM, OP_AND_ZP,
    OP_ORA_IMM, OP_ORA_ZP, OP_EOR_IMM, OP_EOR_ZP, OP_CMP_IMM, OP_CMP_ZP,
    OP_LDA_IMM, OP_LDA_ZP, OP_STA_ZP, OP_ASL_ACC, OP_ASL_ZP, OP_LSR_ACC,
    OP_LSR_ZP, OP_ROL_ACC, OP_ROL_ZP, OP_ROR_ACC, OP_ROR_ZP, OP_CLC,
    OP_SEC, OP_CLV, OP_NOP
  };

  // Opcode in the high byte, operand in the low byte
  localparam logic [15:0] DIRECTED [42] = '{
    // Adds and subtracts, signed overflow both ways
    16'h18_00, 16'hA9_50, 16'h69_50, 16'h69_70,
    16'h85_03, 16'h38_00, 16'hA9_50, 16'hE9_B0,
    16'hB8_00, 16'hE5_13, 16'h65_03, 16'hC9_10,
    16'hC5_03, 16'hC9_FF,
    // Logic ops, store with address wrap
    16'hA9_F0, 16'h29_3C, 16'h09_81, 16'h49_FF,
    16'h85_25, 16'hA9_00, 16'hA5_05, 16'h45_05,
    16'h25_15, 16'h05_15,
    // Shifts and rotates, accumulator then memory
    16'h0A_00, 16'h2A_00, 16'h4A_00, 16'h6A_00,
    16'h06_05, 16'h26_15, 16'h46_05, 16'h66_05,
    16'hA5_05, 16'h38_00, 16'hEA_00, 16'h18_00,
    // Unsupported, BRK SED CLI and absolute forms
    16'h00_00, 16'hF8_00, 16'h58_00, 16'hFF_12,
    16'h89_04, 16'h6D_05
  };

  logic        clk;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [7:0]  cmd_opcode;
  logic [7:0]  cmd_operand;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [7:0]  rsp_acc;
  logic [7:0]  rsp_status;
  logic        rsp_illegal;
  int          error_count;
  int          check_count;
  logic        pending;
  int          timeouts;
  logic        backpressure;
  logic [31:0] rng_state;

  mos_exec_top mos_exec_top_i (.*);

  mos_exec_checker check_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Ready held high unless back-pressure is on
  function automatic logic draw_ready();
    return backpressure ? ((next_random() % 32'd3) != 32'd0) : 1'b1;
  endfunction

  // ------------------------------
  // One instruction, held until accepted
  // ------------------------------
  task automatic issue(input logic [7:0] op, input logic [7:0] operand);
    int t;
    // Presented while the previous response may still be outstanding
    cmd_valid   = 1'b1;
    cmd_opcode  = op;
    cmd_operand = operand;
    t = 0;
    while (!cmd_ready && t < TIMEOUT) begin
      // Previous response drains meanwhile
      rsp_ready = draw_ready();
      @(negedge clk);
      t++;
    end
    if (!cmd_ready) begin
      timeouts++;
      cmd_valid = 1'b0;
      $display("Timeout: DUT never became ready for opcode %h", op);
      return;
    end
    // Accepted on the rising edge in between
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic drain_response();
    int t;
    t = 0;
    while (pending && t < TIMEOUT) begin
      rsp_ready = draw_ready();
      @(negedge clk);
      t++;
    end
    if (pending) begin
      timeouts++;
      $display("Timeout: last response was never consumed");
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  op;
    logic [7:0]  opd;
    rng_state    = 32'h9586_7920;
    timeouts     = 0;
    backpressure = 1'b0;
    reset        = 1'b1;
    cmd_valid    = 1'b0;
    cmd_opcode   = 8'h00;
    cmd_operand  = 8'h00;
    rsp_ready    = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Reset state, then every zero-page byte
    issue(OP_LDA_IMM, 8'h00);
    for (int i = 0; i < 16; i++) begin
      issue(OP_LDA_ZP, 8'(i));
    end
    for (int i = 0; i < 42; i++) begin
      issue(DIRECTED[6'(i)][15:8], DIRECTED[6'(i)][7:0]);
    end

    // Random mix, mostly legal opcodes, ready dropped at random
    backpressure = 1'b1;
    for (int i = 0; i < RANDOM_CMDS; i++) begin
      r = next_random();
      if (r[2:0] == 3'b000) begin
        op = r[15:8];
      end else begin
        op = LEGAL_OPS[5'(r[31:16] % 16'd27)];
      end
      r   = next_random();
      opd = r[7:0];
      issue(op, opd);
    end
    drain_response();

    $display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             check_count, error_count, mos_exec_top_i.assertions_i.failures, timeouts);
    if (error_count == 0 && timeouts == 0 && !pending &&
        mos_exec_top_i.assertions_i.failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- dv/mos_exec_checker.sv
// ------------------------------
// Execute stage checker
// Reference model of A, P and zero
// page, predicts each response
// and its cycle count
// ------------------------------

module mos_exec_checker
  import mos_isa_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_valid,
  input  logic       cmd_ready,
  input  logic [7:0] cmd_opcode,
  input  logic [7:0] cmd_operand,
  input  logic       rsp_valid,
  input  logic       rsp_ready,
  input  logic [7:0] rsp_acc,
  input  logic [7:0] rsp_status,
  input  logic       rsp_illegal,
  output int         error_count,
  output int         check_count,
  output logic       pending
);
  timeunit 1ns;
  timeprecision 1ps;

  // Predicted state after one instruction
  typedef struct packed {
    logic [7:0] a;
    logic [7:0] p;
    logic [7:0] m;
    logic       m_we;
    logic       illegal;
    logic [2:0] n;
  } ref_t;

  logic [7:0] model_a;
  logic [7:0] model_p;
  logic [7:0] model_m [16];
  ref_t       pred;
  int         lat;
  logic       seen_valid;

  // ------------------------------
  // Reference, from 6502 encoding
  // ------------------------------
  function automatic ref_t ref_exec(input logic [7:0] op, input logic [7:0] opd,
                                    input logic [7:0] a, input logic [7:0] p,
                                    input logic [7:0] m);
    ref_t       r;
    logic       zp;
    logic [7:0] v;
    logic [7:0] vs;
    logic [7:0] src;
    logic [7:0] res;
    logic [7:0] nf;
    logic [7:0] mask;
    logic [8:0] s;
    r.a       = a;
    r.p       = p;
    r.m       = m;
    r.m_we    = 1'b0;
    r.illegal = 1'b0;
    // Addressing mode bits 4:2, 001 is zero page
    zp   = (op[4:2] == 3'b001);
    v    = zp ? m : opd;
    res  = a;
    nf   = 8'h00;
    mask = 8'h00;
    r.n  = zp ? 3'd3 : 3'd2;
    if (op[1:0] == 2'b01 && (zp || op[4:2] == 3'b010) && op != 8'h89) begin
      // ALU group, N and Z by default
      mask = 8'h82;
      case (op[7:5])
        3'd0: res = a | v;
        3'd1: res = a & v;
        3'd2: res = a ^ v;
        3'd4: mask = 8'h00;
        3'd5: res = v;
        3'd6: begin
          res   = a - v;
          nf[0] = (a >= v);
          mask  = 8'h83;
        end
        default: begin
          // ADC, SBC adds the complement
          vs    = op[7] ? ~v : v;
          s     = {1'b0, a} + {1'b0, vs} + 9'(p[0]);
          res   = s[7:0];
          nf[0] = s[8];
          nf[6] = (a[7] == vs[7]) && (res[7] != a[7]);
          mask  = 8'hC3;
        end
      endcase
      if (op[7:5] == 3'd4) begin
        r.m    = a;
        r.m_we = 1'b1;
      end else if (op[7:5] != 3'd6) begin
        r.a = res;
      end
    end else if (op[1:0] == 2'b10 && !op[7] && (zp || op[4:2] == 3'b010)) begin
      // Shift group, memory form is read-modify-write
      src = zp ? m : a;
      case (op[6:5])
        2'd0:    {nf[0], res} = {src, 1'b0};
        2'd1:    {nf[0], res} = {src, p[0]};
        2'd2:    {res, nf[0]} = {1'b0, src};
        default: {res, nf[0]} = {p[0], src};
      endcase
      mask = 8'h83;
      if (zp) begin
        r.m    = res;
        r.m_we = 1'b1;
        r.n    = 3'd5;
      end else begin
        r.a = res;
      end
    end else begin
      r.n = 3'd2;
      case (op)
        OP_CLC: mask = 8'h01;
        OP_SEC: begin
          mask  = 8'h01;
          nf[0] = 1'b1;
        end
        OP_CLV:  mask = 8'h40;
        OP_NOP:  mask = 8'h00;
        default: r.illegal = 1'b1;
      endcase
    end
    nf[7] = res[7];
    nf[1] = (res == 8'h00);
    r.p   = (p & ~mask) | (nf & mask);
    return r;
  endfunction

  task automatic compare(input string name, input logic [7:0] want, input logic [7:0] got);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, want, got);
    end
  endtask

  // ------------------------------
  // Sampled on the rising edge
  // ------------------------------
  always @(posedge clk) begin
    if (reset) begin
      model_a     = 8'h00;
      // U and B set after reset
      model_p     = 8'h30;
      model_m     = '{default: 8'h00};
      pending     = 1'b0;
      error_count = 0;
      check_count = 0;
    end else begin
      if (rsp_valid && !pending) begin
        error_count++;
        $display("Response raised at %0t ns with no command outstanding", $time);
      end
      // Cycles from accept to first valid
      if (pending && !seen_valid) begin
        if (rsp_valid) begin
          seen_valid = 1'b1;
          check_count++;
          if (lat != int'(pred.n)) begin
            error_count++;
            $display("[FAIL] %0t ns rsp_valid latency expected %0d actual %0d",
                     $time, pred.n, lat);
          end
        end else begin
          lat++;
        end
      end
      if (pending && rsp_valid && rsp_ready) begin
        compare("rsp_acc", pred.a, rsp_acc);
        compare("rsp_status", pred.p, rsp_status);
        compare("rsp_illegal", {7'd0, pred.illegal}, {7'd0, rsp_illegal});
        pending = 1'b0;
      end
      if (cmd_valid && cmd_ready) begin
        if (pending) begin
          error_count++;
          $display("Command accepted at %0t ns while a response is outstanding", $time);
        end
        // 16-byte page, upper operand bits wrap
        pred = ref_exec(cmd_opcode, cmd_operand, model_a, model_p,
                        model_m[cmd_operand[3:0]]);
        model_a = pred.a;
        model_p = pred.p;
        if (pred.m_we) begin
          model_m[cmd_operand[3:0]] = pred.m;
        end
        pending    = 1'b1;
        seen_valid = 1'b0;
        lat        = 0;
      end
    end
  end

endmodule

//--- dv/mos_exec_assertions.sv
// ------------------------------
// Execute stage assertions
// Handshake and status invariants
// ------------------------------

module mos_exec_assertions
  import mos_isa_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       cmd_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input logic [7:0] rsp_acc,
  input logic [7:0] rsp_status,
  input logic       rsp_illegal
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure count, read by the testbench at the end
  int failures = 0;

  // Ready only in IDLE, valid only in RESP
  ready_valid_excl: assert property (@(posedge clk) disable iff (reset)
    !(cmd_ready && rsp_valid))
    else begin
      failures++;
      $error("cmd_ready and rsp_valid high together");
    end

  // Held response keeps its data
  rsp_hold: assert property (@(posedge clk) disable iff (reset)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_acc) &&
    $stable(rsp_status) && $stable(rsp_illegal))
    else begin
      failures++;
      $error("response dropped or changed before it was consumed");
    end

  status_ub_set: assert property (@(posedge clk) disable iff (reset)
    rsp_status[FLAG_U] && rsp_status[FLAG_B])
    else begin
      failures++;
      $error("status bit U or B read as zero");
    end

  reset_no_rsp: assert property (@(posedge clk) reset |=> !rsp_valid)
    else begin
      failures++;
      $error("rsp_valid high in the cycle after reset");
    end

endmodule

bind mos_exec_top mos_exec_assertions assertions_i (
  .clk(clk),
  .reset(reset),
  .cmd_ready(cmd_ready),
  .rsp_valid(rsp_valid),
  .rsp_ready(rsp_ready),
  .rsp_acc(rsp_acc),
  .rsp_status(rsp_status),
  .rsp_illegal(rsp_illegal)
);

//--- logic/mos_exec_top.sv
// ------------------------------
// 6502 execute stage top
// Decoder, ALU, sequencer, timer,
// zero page and A/P registers
// ------------------------------

module mos_exec_top
  import mos_isa_pkg::*;
  import exec_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  logic [7:0] cmd_opcode,
  input  logic [7:0] cmd_operand,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic [7:0] rsp_acc,
  output logic [7:0] rsp_status,
  output logic       rsp_illegal
);

  logic [7:0]       cur_opcode;
  logic [7:0]       cur_operand;
  alu_op_e          alu_op;
  logic             src_zp;
  dst_e             dst;
  logic [7:0]       flag_mask;
  logic [CYC_W-1:0] cycles;
  logic             illegal;
  logic             timer_load;
  logic             timer_done;
  logic             commit;
  logic [7:0]       zp_rd;
  logic [7:0]       alu_a;
  logic [7:0]       alu_b;
  logic [7:0]       alu_result;
  logic [7:0]       alu_flags;
  logic [7:0]       acc;
  logic [7:0]       status;

  // ------------------------------
  // Operand select and write enables
  // ------------------------------
  assign alu_b = src_zp ? zp_rd : cur_operand;
  // Memory shifts operate on the zero-page byte, everything else on A
  assign alu_a = (src_zp && (dst == DST_ZP)) ? zp_rd : acc;

  assign rsp_acc     = acc;
  assign rsp_status  = status;
  assign rsp_illegal = illegal;

  exec_fsm exec_fsm_i (
    .clk, .reset, .cmd_valid, .cmd_ready, .cmd_opcode, .cmd_operand,
    .timer_done, .timer_load, .cur_opcode, .cur_operand, .commit,
    .rsp_valid, .rsp_ready
  );

  opcode_decode opcode_decode_i (
    .opcode(cur_opcode), .alu_op, .src_zp, .dst, .flag_mask, .cycles, .illegal
  );

  cycle_timer cycle_timer_i (
    .clk, .reset, .load(timer_load), .cycles, .done(timer_done)
  );

  mos_alu mos_alu_i (
    .alu_op, .a(alu_a), .b(alu_b), .carry_in(status[FLAG_C]),
    .result(alu_result), .flags(alu_flags)
  );

  // Address wraps on the low operand bits
  zp_ram zp_ram_i (
    .clk, .reset, .addr(cur_operand[ZP_ADDR_W-1:0]),
    .wr_en(commit && (dst == DST_ZP)), .wr_data(alu_result), .rd_data(zp_rd)
  );

  acc_status_regs acc_status_regs_i (
    .clk, .reset,
    .acc_we(commit && (dst == DST_ACC)), .acc_in(alu_result),
    .flag_we(commit && !illegal), .flag_mask, .flags_in(alu_flags),
    .acc, .status
  );

endmodule

//--- logic/acc_status_regs.sv
// ------------------------------
// Accumulator and status register
// Flags load under a bit mask
// ------------------------------

module acc_status_regs
  import mos_isa_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       acc_we,
  input  logic [7:0] acc_in,
  input  logic       flag_we,
  input  logic [7:0] flag_mask,
  input  logic [7:0] flags_in,
  output logic [7:0] acc,
  output logic [7:0] status
);

  logic [7:0] acc_q;
  logic [7:0] p_q;
  // Only N V Z C are ever written
  logic [7:0] wr_mask;

  assign wr_mask = flag_mask & MASK_NVZC;
  assign acc     = acc_q;

  // U and B read as one, D and I stay clear
  always_comb begin
    status         = p_q;
    status[FLAG_U] = 1'b1;
    status[FLAG_B] = 1'b1;
    status[FLAG_D] = 1'b0;
    status[FLAG_I] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= 8'h00;
      p_q   <= STATUS_RESET;
    end else begin
      if (acc_we) begin
        acc_q <= acc_in;
      end
      if (flag_we) begin
        p_q <= (p_q & ~wr_mask) | (flags_in & wr_mask);
      end
    end
  end

endmodule

//--- logic/zp_ram.sv
// ------------------------------
// Zero-page memory, 16 bytes
// Async read, sync write
// ------------------------------

module zp_ram
  import exec_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [ZP_ADDR_W-1:0] addr,
  input  logic                 wr_en,
  input  logic [7:0]           wr_data,
  output logic [7:0]           rd_data
);

  logic [7:0] mem [ZP_DEPTH];

  assign rd_data = mem[addr];

  always_ff @(posedge clk) begin
    if (reset) begin
      // Zero page starts cleared
      for (int i = 0; i < ZP_DEPTH; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (wr_en) begin
      mem[addr] <= wr_data;
    end
  end

endmodule

//--- logic/cycle_timer.sv
// ------------------------------
// Cycle cost timer
// Down-counter, done on the last
// execute cycle
// ------------------------------

module cycle_timer
  import exec_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             load,
  input  logic [CYC_W-1:0] cycles,
  output logic             done
);

  logic [CYC_W-1:0] count_q;
  logic             run_q;

  assign done = run_q && (count_q == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
      run_q   <= 1'b0;
    end else if (load) begin
      // Accept edge already counts as one cycle
      count_q <= cycles - 1'b1;
      run_q   <= 1'b1;
    end else if (run_q) begin
      if (count_q == '0) begin
        run_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- logic/exec_fsm.sv
// ------------------------------
// Execute sequencer
// Accepts one instruction, waits
// its cycle cost, commits, then
// holds the response
// ------------------------------

module exec_fsm
  import exec_cfg_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  logic [7:0] cmd_opcode,
  input  logic [7:0] cmd_operand,
  input  logic       timer_done,
  output logic       timer_load,
  output logic [7:0] cur_opcode,
  output logic [7:0] cur_operand,
  output logic       commit,
  output logic       rsp_valid,
  input  logic       rsp_ready
);

  exec_state_e state_q;
  logic [7:0]  opcode_q;
  logic [7:0]  operand_q;

  assign cmd_ready  = (state_q == IDLE);
  assign timer_load = cmd_valid && cmd_ready;
  // Single write pulse on the last execute cycle
  assign commit     = (state_q == EXEC) && timer_done;
  assign rsp_valid  = (state_q == RESP);

  // Decoder sees the incoming opcode while idle
  // so the timer loads the right cost on accept
  assign cur_opcode  = (state_q == IDLE) ? cmd_opcode : opcode_q;
  assign cur_operand = operand_q;

  // Instruction hold
  always_ff @(posedge clk) begin
    if (timer_load) begin
      opcode_q  <= cmd_opcode;
      operand_q <= cmd_operand;
    end
  end

  // ------------------------------
  // State sequence
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (timer_load) state_q <= EXEC;
        EXEC:    if (timer_done) state_q <= RESP;
        RESP:    if (rsp_ready) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/mos_alu.sv
// ------------------------------
// 6502 ALU, binary mode only
// Result byte plus N V Z C for
// one operation
// ------------------------------

module mos_alu
  import mos_isa_pkg::*;
(
  input  alu_op_e    alu_op,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  logic       carry_in,
  output logic [7:0] result,
  output logic [7:0] flags
);

  // Nine-bit adder output, bit 8 is carry out
  logic [8:0] sum;
  // N and Z follow the result
  logic       nz_en;

  always_comb begin
    sum    = '0;
    result = a;
    flags  = '0;
    nz_en  = 1'b1;

    case (alu_op)
      ALU_ADD: begin
        sum    = {1'b0, a} + {1'b0, b} + 9'(carry_in);
        result = sum[7:0];
        flags[FLAG_C] = sum[8];
        // Like signs in, other sign out
        flags[FLAG_V] = (a[7] == b[7]) && (result[7] != a[7]);
      end
      ALU_SUB: begin
        // Borrow is inverted carry
        sum    = {1'b0, a} + {1'b0, ~b} + 9'(carry_in);
        result = sum[7:0];
        flags[FLAG_C] = sum[8];
        flags[FLAG_V] = (a[7] != b[7]) && (result[7] != a[7]);
      end
      ALU_CMP: begin
        // Difference for N and Z only, carry means a >= b
        sum    = {1'b0, a} + {1'b0, ~b} + 9'd1;
        result = sum[7:0];
        flags[FLAG_C] = sum[8];
      end
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_PASS: result = b;
      // Shifts, outgoing bit lands in C
      ALU_ASL: begin
        result = {a[6:0], 1'b0};
        flags[FLAG_C] = a[7];
      end
      ALU_LSR: begin
        result = {1'b0, a[7:1]};
        flags[FLAG_C] = a[0];
      end
      ALU_ROL: begin
        result = {a[6:0], carry_in};
        flags[FLAG_C] = a[7];
      end
      ALU_ROR: begin
        result = {carry_in, a[7:1]};
        flags[FLAG_C] = a[0];
      end
      ALU_SETC: begin
        flags[FLAG_C] = 1'b1;
        nz_en = 1'b0;
      end
      // CLC, CLV, NOP leave flags at zero
      default: nz_en = 1'b0;
    endcase

    if (nz_en) begin
      flags[FLAG_N] = result[7];
      flags[FLAG_Z] = (result == 8'h00);
    end
  end

endmodule

//--- logic/opcode_decode.sv
// ------------------------------
// Opcode decoder
// Maps an opcode byte to ALU op,
// operand source, write-back,
// flag mask and cycle cost
// ------------------------------

module opcode_decode
  import mos_isa_pkg::*;
  import exec_cfg_pkg::*;
(
  input  logic [7:0]       opcode,
  output alu_op_e          alu_op,
  output logic             src_zp,
  output dst_e             dst,
  output logic [7:0]       flag_mask,
  output logic [CYC_W-1:0] cycles,
  output logic             illegal
);

  always_comb begin
    alu_op    = ALU_NOP;
    src_zp    = 1'b0;
    dst       = DST_NONE;
    flag_mask = '0;
    cycles    = CYC_SHORT;
    illegal   = 1'b0;

    // Operation select
    case (opcode)
      OP_ADC_IMM, OP_ADC_ZP: alu_op = ALU_ADD;
      OP_SBC_IMM, OP_SBC_ZP: alu_op = ALU_SUB;
      OP_CMP_IMM, OP_CMP_ZP: alu_op = ALU_CMP;
      OP_AND_IMM, OP_AND_ZP: alu_op = ALU_AND;
      OP_ORA_IMM, OP_ORA_ZP: alu_op = ALU_OR;
      OP_EOR_IMM, OP_EOR_ZP: alu_op = ALU_XOR;
      OP_LDA_IMM, OP_LDA_ZP: alu_op = ALU_PASS;
      OP_ASL_ACC, OP_ASL_ZP: alu_op = ALU_ASL;
      OP_LSR_ACC, OP_LSR_ZP: alu_op = ALU_LSR;
      OP_ROL_ACC, OP_ROL_ZP: alu_op = ALU_ROL;
      OP_ROR_ACC, OP_ROR_ZP: alu_op = ALU_ROR;
      OP_SEC:                alu_op = ALU_SETC;
      OP_CLC:                alu_op = ALU_CLRC;
      OP_CLV:                alu_op = ALU_CLRV;
      // STA passes A through untouched
      OP_STA_ZP, OP_NOP:     alu_op = ALU_NOP;
      default:               illegal = 1'b1;
    endcase

    // Zero-page reads pay one extra cycle
    case (opcode)
      OP_ADC_ZP, OP_SBC_ZP, OP_CMP_ZP, OP_AND_ZP,
      OP_ORA_ZP, OP_EOR_ZP, OP_LDA_ZP: begin
        src_zp = 1'b1;
        cycles = CYC_ZP;
      end
      // Read-modify-write on memory
      OP_ASL_ZP, OP_LSR_ZP, OP_ROL_ZP, OP_ROR_ZP: begin
        src_zp = 1'b1;
        cycles = CYC_RMW;
      end
      OP_STA_ZP: cycles = CYC_ZP;
      default: ;
    endcase

    // Write-back target and affected flags
    case (alu_op)
      ALU_ADD, ALU_SUB: begin
        dst       = DST_ACC;
        flag_mask = MASK_NVZC;
      end
      ALU_CMP: flag_mask = MASK_NZC;
      ALU_AND, ALU_OR, ALU_XOR, ALU_PASS: begin
        dst       = DST_ACC;
        flag_mask = MASK_NZ;
      end
      ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR: begin
        dst       = src_zp ? DST_ZP : DST_ACC;
        flag_mask = MASK_NZC;
      end
      ALU_SETC, ALU_CLRC: flag_mask = MASK_C;
      ALU_CLRV:           flag_mask = MASK_V;
      default:            dst = (opcode == OP_STA_ZP) ? DST_ZP : DST_NONE;
    endcase
  end

endmodule

//--- logic/exec_cfg_pkg.sv
// ------------------------------
// Execute stage configuration
// Memory size, cycle costs, FSM
// and write-back encodings
// ------------------------------

package exec_cfg_pkg;

  // Zero page, address bits above ZP_ADDR_W wrap
  localparam int ZP_DEPTH  = 16;
  localparam int ZP_ADDR_W = 4;

  // Cycle costs per addressing class
  localparam int CYC_W = 3;
  localparam logic [CYC_W-1:0] CYC_SHORT = 3'd2;
  localparam logic [CYC_W-1:0] CYC_ZP    = 3'd3;
  localparam logic [CYC_W-1:0] CYC_RMW   = 3'd5;

  typedef enum logic [1:0] {IDLE, EXEC, RESP} exec_state_e;

  typedef enum logic [1:0] {DST_NONE, DST_ACC, DST_ZP} dst_e;

endpackage

//--- logic/mos_isa_pkg.sv
// ------------------------------
// 6502 instruction set definitions
// Opcode bytes, ALU operations and
// status flag bit positions
// ------------------------------

package mos_isa_pkg;

  // ALU operation select
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_CMP, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS, ALU_ASL,
    ALU_LSR, ALU_ROL, ALU_ROR, ALU_SETC, ALU_CLRC, ALU_CLRV, ALU_NOP
  } alu_op_e;

  // Status byte bit positions, N V U B D I Z C
  localparam int FLAG_N = 7;
  localparam int FLAG_V = 6;
  localparam int FLAG_U = 5;
  localparam int FLAG_B = 4;
  localparam int FLAG_D = 3;
  localparam int FLAG_I = 2;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  // Status after reset, U and B set
  localparam logic [7:0] STATUS_RESET = 8'h30;

  // Flag groups written by instruction classes
  localparam logic [7:0] MASK_C    = 8'(1 << FLAG_C);
  localparam logic [7:0] MASK_V    = 8'(1 << FLAG_V);
  localparam logic [7:0] MASK_NZ   = 8'((1 << FLAG_N) | (1 << FLAG_Z));
  localparam logic [7:0] MASK_NZC  = MASK_NZ | MASK_C;
  localparam logic [7:0] MASK_NVZC = MASK_NZC | MASK_V;

  // Supported opcodes
  localparam logic [7:0] OP_ADC_IMM = 8'h69, OP_ADC_ZP = 8'h65;
  localparam logic [7:0] OP_SBC_IMM = 8'hE9, OP_SBC_ZP = 8'hE5;
  localparam logic [7:0] OP_AND_IMM = 8'h29, OP_AND_ZP = 8'h25;
  localparam logic [7:0] OP_ORA_IMM = 8'h09, OP_ORA_ZP = 8'h05;
  localparam logic [7:0] OP_EOR_IMM = 8'h49, OP_EOR_ZP = 8'h45;
  localparam logic [7:0] OP_CMP_IMM = 8'hC9, OP_CMP_ZP = 8'hC5;
  localparam logic [7:0] OP_LDA_IMM = 8'hA9, OP_LDA_ZP = 8'hA5;
  localparam logic [7:0] OP_STA_ZP  = 8'h85;
  localparam logic [7:0] OP_ASL_ACC = 8'h0A, OP_ASL_ZP = 8'h06;
  localparam logic [7:0] OP_LSR_ACC = 8'h4A, OP_LSR_ZP = 8'h46;
  localparam logic [7:0] OP_ROL_ACC = 8'h2A, OP_ROL_ZP = 8'h26;
  localparam logic [7:0] OP_ROR_ACC = 8'h6A, OP_ROR_ZP = 8'h66;
  localparam logic [7:0] OP_CLC = 8'h18, OP_SEC = 8'h38;
  localparam logic [7:0] OP_CLV = 8'hB8, OP_NOP = 8'hEA;

endpackage
